/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_zports
FILELIST = filelist.f
LOG      = sim.log
RUNARGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) $(RUNARGS) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* filelist.f */
hdl/zport_addr_pkg.sv
hdl/zport_cfg_pkg.sv
hdl/zbus_if.sv
hdl/zbus_decode.sv
hdl/xt_regfile.sv
hdl/mem_pager.sv
hdl/com_wait_port.sv
hdl/zports_top.sv
tb/zports_props.sv
tb/tb_zports.sv

/* hdl/com_wait_port.sv */
/* COM wait port #xxEF
   latches the access, runs a four-phase req/ack and holds the z80 in wait */

`timescale 1ns/10ps

module com_wait_port
	import zport_addr_pkg::*;
	import zport_cfg_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,
	zbus_if.sink       bus,
	input  logic       wait_ack,
	input  logic [7:0] wait_read,
	output logic       wait_req,
	output logic       wait_rnw,
	output logic       wait_n,
	output logic [2:0] comport_addr,
	output logic [7:0] wait_write,
	output logic [7:0] com_data
);

	wait_state_e state;
	logic com_hit;

	assign com_hit = (bus.wr | bus.rd) && (bus.sel == PSEL_COM);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			state <= W_IDLE;
		else
		begin
			case (state)
				W_IDLE:    if (com_hit) state <= W_REQ; // strobes elsewhere are ignored
				W_REQ:     if (wait_ack) state <= W_RELEASE;
				W_RELEASE: if (!wait_ack) state <= W_IDLE;
				default:   state <= W_IDLE;
			endcase
		end
	end

	// access payload
	always_ff @(posedge zclk)
	begin
		if ((state == W_IDLE) && com_hit)
		begin
			comport_addr <= bus.addr[10:8]; // F8EF..FFEF
			wait_rnw     <= bus.rd;
			if (bus.wr)
				wait_write <= bus.data;
		end
		if ((state == W_REQ) && wait_ack)
			com_data <= wait_read; // valid while ack is up
	end

	assign wait_req = (state == W_REQ);
	assign wait_n   = (state == W_IDLE);

endmodule

/* hdl/mem_pager.sv */
/* pentagon 7FFD and EFF7 paging
   1M page, rom select, 7FFD lock and video page */

`timescale 1ns/10ps

module mem_pager
	import zport_addr_pkg::*;
	import zport_cfg_pkg::*;
#(
	parameter int NUM_RAMPAGE = 4
)
(
	input  logic       zclk,
	input  logic       rst_n,
	zbus_if.sink       bus,
	output logic       p7ffd_wr,
	output page_t      vpage,
	output logic [7:0] p7ffd,
	output logic [7:0] peff7,
	output logic [5:0] pent1m_page,
	output logic       pent1m_rom,
	output logic       pent1m_1m_on,
	output logic       pent1m_ram0_0
);

	// the top page register is the one 7FFD shares
	localparam bit C000_PAGED = (NUM_RAMPAGE > 3);

	logic fd_wr;
	logic eff7_wr;
	logic lock; // 7FFD frozen until reset
	logic block1m;
	logic [7:0] eff7_q;

	assign fd_wr   = bus.wr && (bus.sel == PSEL_FD) && !bus.addr[15] && !lock;
	assign eff7_wr = bus.wr && (bus.sel == PSEL_F7) && bus.addr[8] && !bus.addr[12];
	assign p7ffd_wr = fd_wr & C000_PAGED;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			p7ffd       <= '0;
			pent1m_rom  <= 1'b0;
			pent1m_page <= '0;
			vpage       <= VPAGE_RST;
			lock        <= 1'b0;
			eff7_q      <= '0;
		end
		else
		begin
			if (fd_wr)
			begin
				p7ffd       <= bus.data;
				pent1m_rom  <= bus.data[4];
				pent1m_page <= block1m ? {3'b000, bus.data[2:0]}
					: {bus.data[5], bus.data[7:6], bus.data[2:0]};
				vpage       <= {6'b000001, bus.data[3], 1'b1}; // screen 5 or 7
				lock        <= bus.data[5] & block1m; // 128K lock bit
			end
			else if (bus.wr && (bus.sel == PSEL_XT) && (bus.addr[15:8] == VPAGE))
				vpage <= bus.data;
			if (eff7_wr)
				eff7_q <= bus.data;
		end
	end

	//////////////////////////////////////////////////
	// EFF7 decode

	assign block1m = eff7_q[2];
	assign peff7 = block1m ? {eff7_q[7], 1'b0, eff7_q[5:4], 3'b000, eff7_q[0]} : eff7_q;

	assign pent1m_1m_on  = ~eff7_q[2];
	assign pent1m_ram0_0 = eff7_q[3];

endmodule

/* hdl/xt_regfile.sv */
/* #nnAF extension register file
   video, scroll, interrupt and ram page registers, border and page overrides */

`timescale 1ns/10ps

module xt_regfile
	import zport_addr_pkg::*;
	import zport_cfg_pkg::*;
#(
	parameter int NUM_RAMPAGE = 4
)
(
	input  logic        zclk,
	input  logic        rst_n,
	zbus_if.sink        bus,
	input  logic        p7ffd_wr,
	output page_t       vconf,
	output page_t       tsconf,
	output page_t       sysconf,
	output page_t       memconf,
	output page_t       hint_beg,
	output page_t       im2vect,
	output offs_t       x_offs,
	output offs_t       y_offs,
	output offs_t       vint_beg,
	output logic [3:0]  palsel,
	output logic [7:0]  border,
	output page_t [NUM_RAMPAGE-1:0] xt_rampage,
	output ovr_t        xt_override
);

	logic xt_wr;
	logic fe_wr;
	xt_reg_e xt_idx;
	logic [1:0] rp_idx; // a9..a8 inside the #10 group
	logic rp_ok;
	logic [NUM_RAMPAGE-1:0] ovr;

	assign xt_wr  = bus.wr && (bus.sel == PSEL_XT);
	assign fe_wr  = bus.wr && (bus.sel == PSEL_FE);
	assign xt_idx = xt_reg_e'(bus.addr[15:8]);
	assign rp_idx = bus.addr[9:8];
	assign rp_ok  = (int'(rp_idx) < NUM_RAMPAGE); // only existing page registers

	assign xt_override = ovr_t'(ovr);

	//////////////////////////////////////////////////
	// register writes

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			vconf    <= '0;
			x_offs   <= '0;
			y_offs   <= '0;
			tsconf   <= '0;
			palsel   <= PALSEL_RST;
			sysconf  <= '0;
			memconf  <= '0;
			hint_beg <= HINT_RST;
			vint_beg <= '0;
			im2vect  <= IM2_RST;
			ovr      <= '0;
			for (int i = 0; i < NUM_RAMPAGE; i++)
				xt_rampage[i] <= RAMPAGE_RST[i];
		end
		else
		begin
			if (xt_wr)
			begin
				case (xt_idx)
					VCONF:   vconf <= bus.data;
					XOFFSL:  x_offs[7:0] <= bus.data;
					XOFFSH:  x_offs[8] <= bus.data[0]; // 9th bit only
					YOFFSL:  y_offs[7:0] <= bus.data;
					YOFFSH:  y_offs[8] <= bus.data[0];
					TSCONF:  tsconf <= bus.data;
					PALSEL:  palsel <= bus.data[3:0];
					SYSCONF: sysconf <= bus.data;
					MEMCONF: memconf <= bus.data;
					HSINT:   hint_beg <= bus.data;
					VSINTL:  vint_beg[7:0] <= bus.data;
					VSINTH:  vint_beg[8] <= bus.data[0];
					IM2VECT: im2vect <= bus.data;
					RAMPAGE0, RAMPAGE1, RAMPAGE2, RAMPAGE3:
					begin
						if (rp_ok)
						begin
							xt_rampage[rp_idx] <= bus.data;
							ovr[rp_idx] <= 1'b1; // window follows the xt page now
						end
					end
					default: ;
				endcase
			end
			if (p7ffd_wr)
				ovr[NUM_RAMPAGE-1] <= 1'b0; // #C000 window back to 7FFD
		end
	end

	// border, FE gives the 8 pentagon colours
	always_ff @(posedge zclk)
	begin
		if (fe_wr)
			border <= {5'b11110, bus.data[2:0]};
		else if (xt_wr && (xt_idx == XBORDER))
			border <= bus.data;
	end

endmodule

/* hdl/zbus_decode.sv */
/* z80 I/O cycle decoder
   edge strobes for read and write, port select and port hit */

`timescale 1ns/10ps

module zbus_decode
	import zport_addr_pkg::*;
(
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [15:0] a,
	input  logic [7:0]  din,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	zbus_if.dec         bus,
	output logic        porthit,
	output logic        dataout
);

	logic iowr; // z80 side, asynchronous
	logic iord;
	logic iowr_q; // level at the previous edge
	logic iord_q;
	port_sel_e sel;

	assign iowr = ~(iorq_n | wr_n);
	assign iord = ~(iorq_n | rd_n);

	//////////////////////////////////////////////////
	// strobes

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iowr_q <= 1'b0;
			iord_q <= 1'b0;
			bus.wr <= 1'b0;
			bus.rd <= 1'b0;
		end
		else
		begin
			iowr_q <= iowr;
			iord_q <= iord;
			bus.wr <= iowr & ~iowr_q; // first edge of the cycle only
			bus.rd <= iord & ~iord_q;
		end
	end

	//////////////////////////////////////////////////
	// port select

	always_comb
	begin
		case (a[7:0])
			PORT_FE:  sel = PSEL_FE;
			PORT_XT:  sel = PSEL_XT;
			PORT_FD:  sel = PSEL_FD;
			PORT_F7:  sel = PSEL_F7;
			PORT_COM: sel = PSEL_COM;
			default:  sel = PSEL_NONE;
		endcase
	end

	assign bus.sel  = sel;
	assign bus.addr = a;
	assign bus.data = din;

	// hit goes to the zx bus iorq split
	assign porthit = (sel != PSEL_NONE);
	assign dataout = porthit & iord; // we drive the data bus

endmodule

/* hdl/zbus_if.sv */
/* decoded z80 I/O cycle
   one-cycle strobes plus port select, address and data */

`timescale 1ns/10ps

interface zbus_if import zport_addr_pkg::*; ();

	logic       wr;   // write strobe, one zclk
	logic       rd;   // read strobe, one zclk
	port_sel_e  sel;  // decoded low address byte
	logic [15:0] addr; // full address, high byte carries indexes
	logic [7:0] data; // z80 data bus

	// decoder side
	modport dec
	(
		output wr,
		output rd,
		output sel,
		output addr,
		output data
	);

	// register blocks
	modport sink
	(
		input wr,
		input rd,
		input sel,
		input addr,
		input data
	);

endinterface

/* hdl/zport_addr_pkg.sv */
/* Z80 port address map for the I/O block
   low-byte port numbers, decoded port select and #nnAF register index */

package zport_addr_pkg;

	// low address bytes of the ports kept in this block
	localparam logic [7:0] PORT_FE  = 8'hFE; // border, keyboard, tape
	localparam logic [7:0] PORT_XT  = 8'hAF; // extension registers, index in a15..a8
	localparam logic [7:0] PORT_FD  = 8'hFD; // 7FFD paging
	localparam logic [7:0] PORT_F7  = 8'hF7; // EFF7
	localparam logic [7:0] PORT_COM = 8'hEF; // F8EF..FFEF serial ports

	// decoded low byte, PSEL_NONE means nothing here answers
	typedef enum logic [2:0] {
		PSEL_NONE,
		PSEL_FE,
		PSEL_XT,
		PSEL_FD,
		PSEL_F7,
		PSEL_COM
	} port_sel_e;

	// high byte of an #nnAF access
	typedef enum logic [7:0] {
		VCONF    = 8'h00,
		VPAGE    = 8'h01,
		XOFFSL   = 8'h02,
		XOFFSH   = 8'h03,
		YOFFSL   = 8'h04,
		YOFFSH   = 8'h05,
		TSCONF   = 8'h06,
		PALSEL   = 8'h07,
		XBORDER  = 8'h0F,
		RAMPAGE0 = 8'h10, // #10..#13 are one group
		RAMPAGE1 = 8'h11,
		RAMPAGE2 = 8'h12,
		RAMPAGE3 = 8'h13,
		SYSCONF  = 8'h20,
		MEMCONF  = 8'h21,
		HSINT    = 8'h22,
		VSINTL   = 8'h23,
		VSINTH   = 8'h24,
		IM2VECT  = 8'h25
	} xt_reg_e;

endpackage

/* hdl/zport_cfg_pkg.sv */
/* configuration types for the I/O block
   register widths, page types, reset values and COM wait phases */

package zport_cfg_pkg;

	localparam int PAGE_W = 8; // ram / video page number
	localparam int OFFS_W = 9; // scroll offsets and line positions
	localparam int OVR_W  = 4; // one flag per 16K window

	typedef logic [PAGE_W-1:0] page_t;
	typedef logic [OFFS_W-1:0] offs_t;
	typedef logic [OVR_W-1:0]  ovr_t;

	//////////////////////////////////////////////////
	// reset values

	localparam page_t       VPAGE_RST  = 8'h05; // pentagon screen 5
	localparam page_t       HINT_RST   = 8'd2;
	localparam page_t       IM2_RST    = 8'hFF;
	localparam logic [3:0]  PALSEL_RST = 4'hF;

	// window 0 first: #00, #05, #02, #00
	localparam logic [3:0][PAGE_W-1:0] RAMPAGE_RST = {
		8'h00,
		8'h02,
		8'h05,
		8'h00
	};

	//////////////////////////////////////////////////
	// COM wait handshake

	typedef enum logic [1:0] {
		W_IDLE,    // no request, z80 runs
		W_REQ,     // req up, waiting for ack
		W_RELEASE  // req down, waiting for ack to drop
	} wait_state_e;

endpackage

/* hdl/zports_top.sv */
/* ZX-Spectrum I/O port block, top level
   decoder, extension registers, paging, COM wait port and read-back mux */

`timescale 1ns/10ps

module zports_top
	import zport_addr_pkg::*;
	import zport_cfg_pkg::*;
#(
	parameter int NUM_RAMPAGE = 4
)
(
	input  logic        zclk,
	input  logic        rst_n,
	// z80 bus
	input  logic [15:0] a,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic        porthit,
	output logic        dataout,
	input  logic [4:0]  keys_in,
	input  logic        tape_read,
	// extension registers
	output page_t       vconf,
	output page_t       tsconf,
	output page_t       sysconf,
	output page_t       memconf,
	output page_t       hint_beg,
	output page_t       im2vect,
	output offs_t       x_offs,
	output offs_t       y_offs,
	output offs_t       vint_beg,
	output logic [3:0]  palsel,
	output logic [7:0]  border,
	output page_t [NUM_RAMPAGE-1:0] xt_rampage,
	output ovr_t        xt_override,
	// paging
	output page_t       vpage,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom,
	output logic        pent1m_1m_on,
	output logic        pent1m_ram0_0,
	// serial engine
	input  logic        wait_ack,
	input  logic [7:0]  wait_read,
	output logic        wait_req,
	output logic        wait_rnw,
	output logic        wait_n,
	output logic [2:0]  comport_addr,
	output logic [7:0]  wait_write
);

	logic p7ffd_wr;
	logic [7:0] com_data;

	zbus_if bus ();

	zbus_decode u_decode (.zclk, .rst_n, .a, .din, .iorq_n, .rd_n, .wr_n,
		.bus(bus.dec), .porthit, .dataout);

	xt_regfile #(.NUM_RAMPAGE(NUM_RAMPAGE)) u_xt (.zclk, .rst_n, .bus(bus.sink),
		.p7ffd_wr, .vconf, .tsconf, .sysconf, .memconf, .hint_beg, .im2vect,
		.x_offs, .y_offs, .vint_beg, .palsel, .border, .xt_rampage, .xt_override);

	mem_pager #(.NUM_RAMPAGE(NUM_RAMPAGE)) u_pager (.zclk, .rst_n, .bus(bus.sink),
		.p7ffd_wr, .vpage, .p7ffd, .peff7, .pent1m_page, .pent1m_rom,
		.pent1m_1m_on, .pent1m_ram0_0);

	com_wait_port u_com (.zclk, .rst_n, .bus(bus.sink), .wait_ack, .wait_read,
		.wait_req, .wait_rnw, .wait_n, .comport_addr, .wait_write, .com_data);

	//////////////////////////////////////////////////
	// read-back

	always_comb
	begin
		case (bus.sel)
			PSEL_FE:  dout = {1'b1, tape_read, 1'b0, keys_in};
			PSEL_COM: dout = com_data; // last word from the serial engine
			default:  dout = 8'hFF;
		endcase
	end

endmodule

/* tb/tb_zports.sv */
/* testbench for the Z80 I/O port block
   bus cycles, #nnAF registers, paging, COM handshake with a random responder */

`timescale 1ns/10ps

module tb_zports
	import zport_addr_pkg::*;
();

	logic zclk;
	logic rst_n;
	logic [15:0] a;
	logic [7:0] din;
	logic [7:0] dout;
	logic iorq_n, rd_n, wr_n;
	logic porthit, dataout;
	logic [4:0] keys_in;
	logic tape_read;
	logic [7:0] vconf, tsconf, sysconf, memconf, hint_beg, im2vect;
	logic [8:0] x_offs, y_offs, vint_beg;
	logic [3:0] palsel;
	logic [7:0] border;
	logic [3:0][7:0] xt_rampage;
	logic [3:0] xt_override;
	logic [7:0] vpage, p7ffd, peff7;
	logic [5:0] pent1m_page;
	logic pent1m_rom, pent1m_1m_on, pent1m_ram0_0;
	logic wait_ack;
	logic [7:0] wait_read;
	logic wait_req, wait_rnw, wait_n;
	logic [2:0] comport_addr;
	logic [7:0] wait_write;

	int checks = 0;
	int errors = 0;
	int timeouts = 0;
	logic [31:0] lfsr = 32'h4fdf292e;
	logic [8:0] exp_x = '0; // 9-bit registers built from halves
	logic [8:0] exp_y = '0;
	logic [8:0] exp_vint = '0;
	logic [7:0] last_read = '0; // what the responder handed out last
	xt_reg_e reg_list[19] = '{VCONF, VPAGE, XOFFSL, XOFFSH, YOFFSL, YOFFSH, TSCONF,
		PALSEL, XBORDER, RAMPAGE0, RAMPAGE1, RAMPAGE2, RAMPAGE3, SYSCONF, MEMCONF,
		HSINT, VSINTL, VSINTH, IM2VECT};

	zports_top #(.NUM_RAMPAGE(4)) DUT (.*);

	bind zports_top zports_props u_props (.zclk(zclk), .rst_n(rst_n),
		.porthit(porthit), .dataout(dataout), .wait_req(wait_req),
		.wait_ack(wait_ack), .wait_n(wait_n));

	always #20 zclk = ~zclk;

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic expect_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("[FAIL] %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	////////////////////////////////////////////////
	// z80 bus cycles

	task automatic bus_cycle(input logic [15:0] addr, input logic [7:0] data,
		input logic is_read, output logic [7:0] rdata, output logic hit, output logic en);
		int t;
		@(negedge zclk);
		a = addr;
		din = data;
		iorq_n = 1'b0;
		rd_n = !is_read;
		wr_n = is_read;
		repeat (4) @(negedge zclk);
		for (t = 0; t < 64 && !wait_n; t++) // COM cycles stretch here
			@(negedge zclk);
		if (!wait_n)
		begin
			timeouts++;
			$display("timeout: wait_n stayed low in the I/O cycle at %h", addr);
		end
		rdata = dout;
		hit = porthit;
		en = dataout;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] rdata;
		logic hit, en;
		bus_cycle(addr, data, 1'b0, rdata, hit, en);
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] rdata,
		output logic hit, output logic en);
		bus_cycle(addr, 8'hFF, 1'b1, rdata, hit, en);
	endtask

	task automatic xt_write_and_check(input xt_reg_e idx, input logic [7:0] d);
		logic [7:0] ix;
		ix = idx;
		io_write({ix, PORT_XT}, d);
		case (idx)
			VCONF:   expect_value("vconf", vconf, d);
			VPAGE:   expect_value("vpage", vpage, d);
			XOFFSL:  exp_x[7:0] = d;
			XOFFSH:  exp_x[8] = d[0];
			YOFFSL:  exp_y[7:0] = d;
			YOFFSH:  exp_y[8] = d[0];
			TSCONF:  expect_value("tsconf", tsconf, d);
			PALSEL:  expect_value("palsel", palsel, d[3:0]);
			XBORDER: expect_value("border", border, d);
			SYSCONF: expect_value("sysconf", sysconf, d);
			MEMCONF: expect_value("memconf", memconf, d);
			HSINT:   expect_value("hint_beg", hint_beg, d);
			VSINTL:  exp_vint[7:0] = d;
			VSINTH:  exp_vint[8] = d[0];
			IM2VECT: expect_value("im2vect", im2vect, d);
			default:
			begin
				expect_value("xt_rampage", xt_rampage[ix[1:0]], d);
				expect_value("xt_override bit", xt_override[ix[1:0]], 1'b1);
			end
		endcase
		expect_value("x_offs", x_offs, exp_x);
		expect_value("y_offs", y_offs, exp_y);
		expect_value("vint_beg", vint_beg, exp_vint);
	endtask

	////////////////////////////////////////////////
	// serial engine, acks after 1 to 8 cycles

	initial
	begin
		int cnt;
		cnt = 0;
		wait_ack = 1'b0;
		wait_read = 8'h00;
		forever
		begin
			@(negedge zclk);
			if (wait_ack)
			begin
				if (!wait_req)
					wait_ack = 1'b0;
			end
			else if (wait_req)
			begin
				if (cnt == 0)
					cnt = 1 + int'(rand_bits(3)); // new request
				else if (cnt == 1)
				begin
					wait_read = 8'(rand_bits(8));
					last_read = wait_read;
					wait_ack = 1'b1;
					cnt = 0;
				end
				else
					cnt--;
			end
		end
	end

	initial
	begin
		logic [7:0] d, d_lock, rdata;
		logic hit, en;
		logic [2:0] sel3;
		int i;
		zclk = 1'b0;
		rst_n = 1'b0;
		a = '0;
		din = '0;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		keys_in = '0;
		tape_read = 1'b0;
		repeat (10) @(negedge zclk);
		rst_n = 1'b1;
		@(negedge zclk);

		// reset values
		expect_value("vconf after reset", vconf, 8'h00);
		expect_value("palsel after reset", palsel, 4'hF);
		expect_value("hint_beg after reset", hint_beg, 8'd2);
		expect_value("im2vect after reset", im2vect, 8'hFF);
		expect_value("xt_rampage after reset", xt_rampage, {8'h00, 8'h02, 8'h05, 8'h00});
		expect_value("vpage after reset", vpage, 8'h05);
		expect_value("xt_override after reset", xt_override, 4'h0);
		expect_value("wait_req after reset", wait_req, 1'b0);
		expect_value("wait_n after reset", wait_n, 1'b1);

		// every #nnAF register once, then random ones
		for (i = 0; i < 19; i++)
			xt_write_and_check(reg_list[i], 8'(rand_bits(8)));
		for (i = 0; i < 24; i++)
			xt_write_and_check(reg_list[rand_bits(5) % 19], 8'(rand_bits(8)));
		xt_write_and_check(XBORDER, 8'(rand_bits(8)));
		xt_write_and_check(RAMPAGE3, 8'(rand_bits(8))); // arms override bit 3

		// port FE and an unused port
		d = 8'(rand_bits(8));
		io_write(16'h00FE, d);
		expect_value("border after FE write", border, {5'b11110, d[2:0]});
		keys_in = 5'(rand_bits(5));
		tape_read = rand_bits(1) != 0;
		io_read(16'h7FFE, rdata, hit, en);
		expect_value("FE read", rdata, {1'b1, tape_read, 1'b0, keys_in});
		expect_value("porthit on FE read", hit, 1'b1);
		expect_value("dataout on FE read", en, 1'b1);
		io_read(16'h001F, rdata, hit, en);
		expect_value("unused port read", rdata, 8'hFF);
		expect_value("porthit on unused port", hit, 1'b0);

		////////////////////////////////////////////////
		// 7FFD / EFF7 paging

		d = 8'(rand_bits(8));
		io_write(16'h7FFD, d);
		expect_value("vpage after 7FFD", vpage, {6'b000001, d[3], 1'b1});
		expect_value("pent1m_page 1M mode", pent1m_page, {d[5], d[7:6], d[2:0]});
		expect_value("pent1m_rom", pent1m_rom, d[4]);
		expect_value("xt_override bit 3 after 7FFD", xt_override[3], 1'b0);
		d = 8'(rand_bits(8)) | 8'h04; // block1m
		io_write(16'hEFF7, d);
		expect_value("peff7 with block1m", peff7, d & 8'hB1);
		expect_value("pent1m_1m_on", pent1m_1m_on, 1'b0);
		expect_value("pent1m_ram0_0", pent1m_ram0_0, d[3]);
		d = 8'(rand_bits(8)) & 8'hDF;
		io_write(16'h7FFD, d);
		expect_value("pent1m_page 128K mode", pent1m_page, {3'b000, d[2:0]});
		d_lock = 8'(rand_bits(8)) | 8'h20;
		io_write(16'h7FFD, d_lock);
		io_write(16'h7FFD, ~d_lock);
		expect_value("p7ffd after lock", p7ffd, d_lock);
		expect_value("vpage after lock", vpage, {6'b000001, d_lock[3], 1'b1});

		// COM port, writes and reads alternate
		for (i = 0; i < 8; i++)
		begin
			sel3 = 3'(rand_bits(3));
			d = 8'(rand_bits(8));
			if (i % 2 == 0)
			begin
				io_write({5'b11111, sel3, PORT_COM}, d);
				expect_value("wait_write", wait_write, d);
			end
			else
			begin
				io_read({5'b11111, sel3, PORT_COM}, rdata, hit, en);
				expect_value("COM read data", rdata, last_read);
			end
			expect_value("comport_addr", comport_addr, sel3);
			expect_value("wait_rnw", wait_rnw, i % 2);
		end

		repeat (4) @(negedge zclk);
		errors += DUT.u_props.fail_cnt;
		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* tb/zports_props.sv */
/* bound checks on the I/O block top level
   z80 read enable and COM wait handshake rules */

`timescale 1ns/10ps

module zports_props
(
	input logic zclk,
	input logic rst_n,
	input logic porthit,
	input logic dataout,
	input logic wait_req,
	input logic wait_ack,
	input logic wait_n
);

	int unsigned fail_cnt = 0; // failed assertions so far

	//////////////////////////////////////////////////
	// z80 bus

	a_dataout_hit: assert property (@(posedge zclk) disable iff (!rst_n)
		$rose(dataout) |-> porthit)
	else
	begin
		fail_cnt++;
		$error("dataout rose without porthit");
	end

	//////////////////////////////////////////////////
	// COM wait handshake

	a_wait_while_req: assert property (@(posedge zclk) disable iff (!rst_n)
		wait_req |-> !wait_n)
	else
	begin
		fail_cnt++;
		$error("wait_n high while wait_req is high");
	end

	a_req_rise: assert property (@(posedge zclk) disable iff (!rst_n)
		$rose(wait_req) |-> !wait_ack)
	else
	begin
		fail_cnt++;
		$error("wait_req rose while wait_ack was high");
	end

	a_req_hold: assert property (@(posedge zclk) disable iff (!rst_n)
		(wait_req && !wait_ack) |=> wait_req) // req stays up until ack
	else
	begin
		fail_cnt++;
		$error("wait_req dropped before wait_ack rose");
	end

	a_release: assert property (@(posedge zclk) disable iff (!rst_n)
		$rose(wait_n) |-> !$past(wait_ack))
	else
	begin
		fail_cnt++;
		$error("wait_n released before wait_ack went low");
	end

endmodule
